/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_reg_bank
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
src/regbank_pkg.sv
src/reg_port_if.sv
src/reg_counters.sv
src/reg_addr_sel.sv
src/reg_file.sv
src/reg_bank_subsystem.sv
test/reg_bank_checker.sv
test/tb_reg_bank.sv

/* src/reg_addr_sel.sv */
`timescale 1ns/10ps

module reg_addr_sel import regbank_pkg::*; #(
    parameter int unsigned PC_STEP = 4
) (
    input  word_t    ir,
    input  word_t    alu_bus,
    input  word_t    pc,
    input  reg_idx_t rm_cnt,
    input  reg_idx_t rd_cnt,
    input  reg_idx_t rs_cnt,
    input  logic     ir_rd_mux,
    input  logic     ir_rn_mux,
    input  logic     rn_mux,
    input  logic     pc_mux,
    input  logic     rs_mux,
    input  logic     data_mux,
    input  logic     rst_reg,
    input  logic     latch_reg,
    input  logic     write_back,
    input  logic     is_dpi,
    input  logic     is_dpis,
    input  logic     is_dprs,
    input  rm_sel_e  ir_rm_mux,
    input  rd_sel_e  rd_mux,
    reg_port_if.sel  port
);

    reg_idx_t ir_lo_f;
    reg_idx_t ir_rd_f;
    reg_idx_t ir_rn_f;
    reg_idx_t ir_rs_f;
    logic     cmp_family;
    word_t    pc_link;

    // Register fields of the instruction word.
    assign ir_lo_f = ir[3:0];
    assign ir_rs_f = ir[11:8];
    assign ir_rd_f = ir[15:12];
    assign ir_rn_f = ir[19:16];

    always_comb begin
        if (rn_mux) begin
            port.rn = rd_cnt;    // Block transfers read through the Rd counter.
        end else if (pc_mux) begin
            port.rn = PC_IDX;
        end else if (ir_rn_mux) begin
            port.rn = ir_rn_f;
        end else begin
            port.rn = ir_rd_f;
        end
    end

    always_comb begin
        unique case (ir_rm_mux)
            RM_IR_LO: port.rm = ir_lo_f;
            RM_IR_RD: port.rm = ir_rd_f;
            RM_IR_RN: port.rm = ir_rn_f;
            RM_CNT:   port.rm = rm_cnt;
            default:  port.rm = ir_lo_f;
        endcase
    end

    always_comb begin
        unique case (rd_mux)
            RD_IR:   port.rd = ir_rd_mux ? ir_rd_f : ir_rn_f;
            RD_PC:   port.rd = PC_IDX;
            RD_LR:   port.rd = LR_IDX;
            RD_CNT:  port.rd = rd_cnt;
            default: port.rd = ir_rd_f;
        endcase
    end

    assign port.rs = rs_mux ? rs_cnt : ir_rs_f;

    // TST, TEQ, CMP and CMN set flags only and never write Rd.
    assign cmp_family = (is_dpi | is_dpis | is_dprs) & ir[24] & ~ir[23];

    assign port.wr_en = (latch_reg & ~cmp_family) | (write_back & ir[21]);

    assign pc_link = pc + word_t'(PC_STEP);

    always_comb begin
        if (rst_reg) begin
            port.wr_data = '0;
        end else if (data_mux) begin
            port.wr_data = alu_bus;
        end else begin
            port.wr_data = pc_link;
        end
    end

endmodule

/* src/reg_bank_subsystem.sv */
`timescale 1ns/10ps

module reg_bank_subsystem import regbank_pkg::*; #(
    parameter int unsigned PC_STEP = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        latch_reg,
    input  logic        write_back,
    input  logic        ir_rd_mux,
    input  logic        ir_rn_mux,
    input  rm_sel_e     ir_rm_mux,
    input  rd_sel_e     rd_mux,
    input  logic        rn_mux,
    input  logic        pc_mux,
    input  logic        rs_mux,
    input  logic        data_mux,
    input  logic        rst_reg,
    input  logic        gate_b,
    input  logic        gate_c,
    input  logic        is_dpi,
    input  logic        is_dpis,
    input  logic        is_dprs,
    input  cnt_cmd_e    rm_cmd,
    input  cnt_cmd_e    rd_cmd,
    input  logic        rs_reload,
    input  logic        latch_rm,
    input  logic        latch_rd,
    input  logic        latch_rs,
    input  word_t       ir,
    input  word_t       alu_bus,
    output wire  word_t a_bus,
    output wire  word_t b_bus,
    output wire  word_t c_bus,
    output word_t       pc,
    output logic        rm_cntr_done
);

    reg_idx_t rm_cnt;
    reg_idx_t rd_cnt;
    reg_idx_t rs_cnt;

    reg_port_if i_reg_port ();

    reg_counters i_reg_counters (
        .clk          (clk),
        .rst          (rst),
        .latch_rm     (latch_rm),
        .latch_rd     (latch_rd),
        .latch_rs     (latch_rs),
        .rm_cmd       (rm_cmd),
        .rd_cmd       (rd_cmd),
        .rs_reload    (rs_reload),
        .ir           (ir),
        .rm_cnt       (rm_cnt),
        .rd_cnt       (rd_cnt),
        .rs_cnt       (rs_cnt),
        .rm_cntr_done (rm_cntr_done)
    );

    reg_addr_sel #(
        .PC_STEP (PC_STEP)
    ) i_reg_addr_sel (
        .ir         (ir),
        .alu_bus    (alu_bus),
        .pc         (pc),
        .rm_cnt     (rm_cnt),
        .rd_cnt     (rd_cnt),
        .rs_cnt     (rs_cnt),
        .ir_rd_mux  (ir_rd_mux),
        .ir_rn_mux  (ir_rn_mux),
        .rn_mux     (rn_mux),
        .pc_mux     (pc_mux),
        .rs_mux     (rs_mux),
        .data_mux   (data_mux),
        .rst_reg    (rst_reg),
        .latch_reg  (latch_reg),
        .write_back (write_back),
        .is_dpi     (is_dpi),
        .is_dpis    (is_dpis),
        .is_dprs    (is_dprs),
        .ir_rm_mux  (ir_rm_mux),
        .rd_mux     (rd_mux),
        .port       (i_reg_port.sel)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .rst    (rst),
        .gate_b (gate_b),
        .gate_c (gate_c),
        .port   (i_reg_port.bank),
        .a_bus  (a_bus),
        .b_bus  (b_bus),
        .c_bus  (c_bus),
        .pc     (pc)
    );

endmodule

/* src/reg_counters.sv */
`timescale 1ns/10ps

module reg_counters import regbank_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     latch_rm,
    input  logic     latch_rd,
    input  logic     latch_rs,
    input  cnt_cmd_e rm_cmd,
    input  cnt_cmd_e rd_cmd,
    input  logic     rs_reload,
    input  word_t    ir,
    output reg_idx_t rm_cnt,
    output reg_idx_t rd_cnt,
    output reg_idx_t rs_cnt,
    output logic     rm_cntr_done
);

    reg_idx_t rm_next;
    reg_idx_t rd_next;
    reg_idx_t rs_next;

    always_comb begin
        unique case (rm_cmd)
            CNT_INC:  rm_next = rm_cnt + 4'd1;
            CNT_ZERO: rm_next = CNT_ZERO_VAL;
            CNT_BASE: rm_next = RM_BASE;
            CNT_CLR:  rm_next = CNT_ZERO_VAL;
            default:  rm_next = rm_cnt;
        endcase
    end

    always_comb begin
        unique case (rd_cmd)
            CNT_INC:  rd_next = rd_cnt + 4'd1;
            CNT_ZERO: rd_next = CNT_ZERO_VAL;
            CNT_BASE: rd_next = RD_BASE;
            CNT_CLR:  rd_next = CNT_ZERO_VAL;
            default:  rd_next = rd_cnt;
        endcase
    end

    // The reload value depends on the transfer form held in the instruction.
    always_comb begin
        if (!rs_reload) begin
            rs_next = rs_cnt + 4'd1;
        end else if (ir[24:23] == 2'd2) begin
            rs_next = RS_LOAD_HI;
        end else if (ir[21]) begin
            rs_next = RS_LOAD_LO;
        end else begin
            rs_next = RS_LOAD_MID;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rm_cnt <= CNT_ZERO_VAL;
            rd_cnt <= CNT_ZERO_VAL;
            rs_cnt <= CNT_ZERO_VAL;
        end else begin
            if (latch_rm) rm_cnt <= rm_next;
            if (latch_rd) rd_cnt <= rd_next;
            if (latch_rs) rs_cnt <= rs_next;
        end
    end

    assign rm_cntr_done = (rm_cnt == RM_DONE_FIRST) || (rm_cnt == RM_DONE_SECOND);

    a_rm_cmd_known: assert property (
        @(posedge clk) disable iff (rst) latch_rm |-> !$isunknown(rm_cmd)
    ) else $error("rm_cmd unknown while latch_rm is high");

endmodule

/* src/reg_file.sv */
`timescale 1ns/10ps

module reg_file import regbank_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        gate_b,
    input  logic        gate_c,
    reg_port_if.bank    port,
    output wire  word_t a_bus,
    output wire  word_t b_bus,
    output wire  word_t c_bus,
    output word_t       pc
);

    word_t regs [NUM_REGS];

    word_t rn_data;
    word_t rm_data;
    word_t rs_data;

    // Reset has priority, so a write request during rst is dropped.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (port.wr_en) begin
            regs[port.rd] <= port.wr_data;
        end
    end

    // Read ports are combinational and show a write from the next cycle on.
    assign rn_data = regs[port.rn];
    assign rm_data = regs[port.rm];
    assign rs_data = regs[port.rs];

    assign a_bus = rn_data;

    // B and C drive shared operand buses and float when not gated.
    assign b_bus = gate_b ? rm_data : 'z;
    assign c_bus = gate_c ? rs_data : 'z;

    assign pc = regs[PC_IDX];

    a_wr_en_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(port.wr_en)
    ) else $error("Register write enable is unknown");

endmodule

/* src/reg_port_if.sv */
`timescale 1ns/10ps

interface reg_port_if import regbank_pkg::*; ();

    reg_idx_t rn;
    reg_idx_t rm;
    reg_idx_t rs;
    reg_idx_t rd;
    logic     wr_en;     // Qualified write strobe for rd.
    word_t    wr_data;

    modport sel (
        output rn,
        output rm,
        output rs,
        output rd,
        output wr_en,
        output wr_data
    );

    modport bank (
        input rn,
        input rm,
        input rs,
        input rd,
        input wr_en,
        input wr_data
    );

endinterface

/* src/regbank_pkg.sv */
package regbank_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    localparam int unsigned NUM_REGS = 16;

    localparam reg_idx_t PC_IDX = 4'd15;
    localparam reg_idx_t LR_IDX = 4'd14;

    // Block-transfer load values for the counters.
    localparam reg_idx_t RM_BASE  = 4'd5;
    localparam reg_idx_t RD_BASE  = 4'd10;
    localparam reg_idx_t CNT_ZERO_VAL = 4'd0;

    // Rs reload values, picked from instruction bits 24..23 and 21.
    localparam reg_idx_t RS_LOAD_HI  = 4'd11;
    localparam reg_idx_t RS_LOAD_LO  = 4'd0;
    localparam reg_idx_t RS_LOAD_MID = 4'd5;

    // The Rm counter marks the end of a group at these two counts.
    localparam reg_idx_t RM_DONE_FIRST  = 4'd4;
    localparam reg_idx_t RM_DONE_SECOND = 4'd8;

    // Source of the Rm register number.
    typedef enum logic [1:0] {
        RM_IR_LO = 2'd0,
        RM_IR_RD = 2'd1,
        RM_IR_RN = 2'd2,
        RM_CNT   = 2'd3
    } rm_sel_e;

    // Source of the Rd register number.
    typedef enum logic [1:0] {
        RD_IR  = 2'd0,
        RD_PC  = 2'd1,
        RD_LR  = 2'd2,
        RD_CNT = 2'd3
    } rd_sel_e;

    // Commands for the Rm and Rd block-transfer counters.
    typedef enum logic [1:0] {
        CNT_INC  = 2'd0,
        CNT_ZERO = 2'd1,
        CNT_BASE = 2'd2,
        CNT_CLR  = 2'd3
    } cnt_cmd_e;

endpackage

/* test/reg_bank_checker.sv */
`timescale 1ns/10ps

module reg_bank_checker import regbank_pkg::*; #(
    parameter int unsigned PC_STEP = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     latch_reg, write_back, rst_reg, data_mux,
    input  logic     ir_rd_mux, ir_rn_mux, rn_mux, pc_mux, rs_mux,
    input  logic     gate_b, gate_c, is_dpi, is_dpis, is_dprs,
    input  logic     latch_rm, latch_rd, latch_rs, rs_reload,
    input  rm_sel_e  ir_rm_mux,
    input  rd_sel_e  rd_mux,
    input  cnt_cmd_e rm_cmd, rd_cmd,
    input  word_t    ir, alu_bus,
    input  word_t    a_bus, b_bus, c_bus, pc,
    input  logic     rm_cntr_done,
    output int       errors,
    output int       checks
);

    word_t    shadow [16];
    reg_idx_t rm_c;
    reg_idx_t rd_c;
    reg_idx_t rs_c;

    initial begin
        errors = 0;
        checks = 0;
    end

    function automatic reg_idx_t next_count(reg_idx_t cur, cnt_cmd_e cmd, reg_idx_t base);
        if (cmd == CNT_INC) return cur + 4'd1;
        if (cmd == CNT_BASE) return base;
        return 4'd0;    // Zero and clear both load 0.
    endfunction

    function automatic reg_idx_t next_rs(reg_idx_t cur, logic reload, word_t w);
        if (!reload) return cur + 4'd1;
        if (w[24:23] == 2'b10) return 4'd11;
        return w[21] ? 4'd0 : 4'd5;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // A floating net reads as z, or as zero where the simulator has two states.
    task automatic check_released(input string name, input word_t got);
        if (!$isunknown(got) && got != '0) begin
            $display("MISMATCH at %0t: %s is %h, expected high impedance", $time, name, got);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        reg_idx_t rn_i, rm_i, rs_i, rd_i;
        logic     cmp;
        logic     we;
        if (rst) begin
            foreach (shadow[i]) begin
                shadow[i] = '0;
            end
            rm_c = '0;
            rd_c = '0;
            rs_c = '0;
        end else begin
            checks++;
            rn_i = rn_mux ? rd_c : (pc_mux ? 4'd15 : (ir_rn_mux ? ir[19:16] : ir[15:12]));
            case (ir_rm_mux)
                RM_IR_LO: rm_i = ir[3:0];
                RM_IR_RD: rm_i = ir[15:12];
                RM_IR_RN: rm_i = ir[19:16];
                default:  rm_i = rm_c;
            endcase
            case (rd_mux)
                RD_IR:   rd_i = ir_rd_mux ? ir[15:12] : ir[19:16];
                RD_PC:   rd_i = 4'd15;
                RD_LR:   rd_i = 4'd14;
                default: rd_i = rd_c;
            endcase
            rs_i = rs_mux ? rs_c : ir[11:8];
            check_word("a_bus", a_bus, shadow[rn_i]);
            if (gate_b) begin
                check_word("b_bus", b_bus, shadow[rm_i]);
            end else begin
                check_released("b_bus", b_bus);
            end
            if (gate_c) begin
                check_word("c_bus", c_bus, shadow[rs_i]);
            end else begin
                check_released("c_bus", c_bus);
            end
            check_word("pc", pc, shadow[15]);
            if (rm_cntr_done !== (rm_c == 4'd4 || rm_c == 4'd8)) begin
                $display("MISMATCH at %0t: rm_cntr_done is %b at Rm count %0d",
                         $time, rm_cntr_done, rm_c);
                errors++;
            end
            cmp = (is_dpi || is_dpis || is_dprs) && ir[24] && !ir[23];    // Compare family.
            we = (latch_reg && !cmp) || (write_back && ir[21]);
            if (we) begin
                shadow[rd_i] = rst_reg ? '0 : (data_mux ? alu_bus : shadow[15] + word_t'(PC_STEP));
            end
            if (latch_rm) rm_c = next_count(rm_c, rm_cmd, 4'd5);
            if (latch_rd) rd_c = next_count(rd_c, rd_cmd, 4'd10);
            if (latch_rs) rs_c = next_rs(rs_c, rs_reload, ir);
        end
    end

endmodule

/* test/tb_reg_bank.sv */
`timescale 1ns/10ps

module tb_reg_bank import regbank_pkg::*; ();

    localparam int unsigned PC_STEP      = 4;
    localparam int unsigned RESET_CYCLES = 4;
    localparam int unsigned WRITE_ROUNDS = 48;    // Two cycles per round.
    localparam int unsigned CMP_ROUNDS   = 24;
    localparam int unsigned LINK_ROUNDS  = 16;
    localparam int unsigned COUNT_CYCLES = 40;
    localparam int unsigned GATE_CYCLES  = 24;
    localparam int unsigned PHASE_CYCLES = 2 * RESET_CYCLES + COUNT_CYCLES + GATE_CYCLES + 2
        + 2 * (WRITE_ROUNDS + CMP_ROUNDS + LINK_ROUNDS);
    localparam int unsigned MAX_CYCLES   = 2 * PHASE_CYCLES;

    logic       clk;
    logic       rst;
    logic       latch_reg, write_back, rst_reg, data_mux;
    logic       ir_rd_mux, ir_rn_mux, rn_mux, pc_mux, rs_mux;
    logic       gate_b, gate_c, is_dpi, is_dpis, is_dprs;
    logic       latch_rm, latch_rd, latch_rs, rs_reload;
    rm_sel_e    ir_rm_mux;
    rd_sel_e    rd_mux;
    cnt_cmd_e   rm_cmd, rd_cmd;
    word_t      ir, alu_bus;
    wire word_t a_bus, b_bus, c_bus;
    word_t      pc;
    logic       rm_cntr_done;
    int         errors, checks;
    int         cycles = 0;
    int         seed = 32'haee73c88;

    always #10 clk = ~clk;

    reg_bank_subsystem #(
        .PC_STEP (PC_STEP)
    ) i_reg_bank_subsystem (.*);

    reg_bank_checker #(
        .PC_STEP (PC_STEP)
    ) i_reg_bank_checker (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the stimulus did not finish", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Strobes off and both buses gated; the selects keep their values.
    task automatic quiet_controls();
        latch_reg = 1'b0;
        write_back = 1'b0;
        rst_reg = 1'b0;
        data_mux = 1'b1;
        is_dpi = 1'b0;
        is_dpis = 1'b0;
        is_dprs = 1'b0;
        latch_rm = 1'b0;
        latch_rd = 1'b0;
        latch_rs = 1'b0;
        gate_b = 1'b1;
        gate_c = 1'b1;
    endtask

    task automatic write_and_read_back(input int unsigned rounds);
        for (int unsigned i = 0; i < rounds; i++) begin
            @(negedge clk);
            quiet_controls();
            ir = $random(seed);
            alu_bus = $random(seed);
            latch_reg = 1'b1;
            ir_rd_mux = 1'($random(seed));
            rd_mux = (i % 3 == 0) ? RD_CNT : RD_IR;
            @(negedge clk);
            quiet_controls();    // Same ir, so the fields still name the written register.
            rn_mux = (i % 3 == 0);
            pc_mux = 1'b0;
            ir_rn_mux = ~ir_rd_mux;
            ir_rm_mux = rm_sel_e'(2'(i));
            rs_mux = 1'($random(seed));
            latch_rd = 1'($random(seed));
            rd_cmd = cnt_cmd_e'(2'($random(seed)));
        end
    endtask

    task automatic compare_family(input int unsigned rounds);
        for (int unsigned i = 0; i < rounds; i++) begin
            @(negedge clk);
            quiet_controls();
            ir = $random(seed);
            ir[24] = 1'b1;
            ir[23] = 1'b0;
            alu_bus = $random(seed);
            rd_mux = RD_IR;
            ir_rd_mux = 1'b1;
            latch_reg = 1'b1;
            write_back = 1'($random(seed));    // Forces the write when ir[21] is set.
            case (i % 3)
                0: is_dpi = 1'b1;
                1: is_dpis = 1'b1;
                default: is_dprs = 1'b1;
            endcase
            @(negedge clk);
            quiet_controls();
            rn_mux = 1'b0;
            pc_mux = 1'b0;
            ir_rn_mux = 1'b0;
        end
    endtask

    task automatic link_writes(input int unsigned rounds);
        for (int unsigned i = 0; i < rounds; i++) begin
            @(negedge clk);
            quiet_controls();
            ir = $random(seed);
            ir[15:12] = LR_IDX;
            data_mux = 1'b0;
            latch_reg = 1'b1;
            rd_mux = i[0] ? RD_LR : RD_PC;
            rst_reg = (i % 8 >= 6);
            @(negedge clk);
            quiet_controls();
            rn_mux = 1'b0;
            pc_mux = ~i[0];    // Odd rounds read r14 back through the Rd field.
            ir_rn_mux = 1'b0;
        end
    endtask

    // The Rm counter starts from zero and steps past counts 4 and 8.
    task automatic step_counters(input int unsigned n);
        for (int unsigned i = 0; i < n; i++) begin
            @(negedge clk);
            quiet_controls();
            ir = $random(seed);
            latch_rm = 1'b1;
            latch_rd = 1'($random(seed));
            latch_rs = 1'($random(seed));
            rs_reload = 1'($random(seed));
            rd_cmd = cnt_cmd_e'(2'($random(seed)));
            if (i == 0) rm_cmd = CNT_ZERO;
            else if (i < 12) rm_cmd = CNT_INC;
            else rm_cmd = cnt_cmd_e'(2'($random(seed)));
            rn_mux = 1'($random(seed));
            ir_rm_mux = RM_CNT;
            rs_mux = 1'b1;
        end
    endtask

    task automatic gated_reads(input int unsigned n);
        for (int unsigned i = 0; i < n; i++) begin
            @(negedge clk);
            quiet_controls();
            ir = $random(seed);
            rn_mux = 1'b0;
            pc_mux = 1'b0;
            ir_rn_mux = 1'($random(seed));
            ir_rm_mux = rm_sel_e'(2'($random(seed)));
            rs_mux = 1'($random(seed));
            gate_b = 1'($random(seed));
            gate_c = 1'($random(seed));
        end
    endtask

    task automatic reset_under_traffic();
        @(negedge clk);
        rst = 1'b1;
        rd_mux = RD_PC;
        latch_reg = 1'b1;    // Dropped, reset wins.
        alu_bus = $random(seed);
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        quiet_controls();
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        quiet_controls();
        ir_rd_mux = 1'b1;
        ir_rn_mux = 1'b1;
        rn_mux = 1'b0;
        pc_mux = 1'b0;
        rs_mux = 1'b0;
        ir_rm_mux = RM_IR_LO;
        rd_mux = RD_IR;
        rm_cmd = CNT_INC;
        rd_cmd = CNT_INC;
        rs_reload = 1'b0;
        ir = '0;
        alu_bus = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        write_and_read_back(WRITE_ROUNDS);
        compare_family(CMP_ROUNDS);
        link_writes(LINK_ROUNDS);
        step_counters(COUNT_CYCLES);
        gated_reads(GATE_CYCLES);
        reset_under_traffic();
        $display("Checked %0d cycles, %0d mismatches", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
